/* Makefile */
# Verilator simulation of the shell register path

VERILATOR ?= verilator
TOP       ?= tb_shell_bus
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  := Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* design/shell_addr_decode.sv */
// Decode stage of the shell register path
// Registers each host request together with its address region

module shell_addr_decode (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic                    req_valid_i,
    input  shell_bus_pkg::bus_req_t req_i,
    output logic                    dec_valid_o,
    output shell_map_pkg::dec_req_t dec_req_o
);

    import shell_bus_pkg::*;
    import shell_map_pkg::*;

    region_e region_d;
    addr_t   ctrl_ofs;

    // ========================================================================
    // Region classification
    // ========================================================================
    always_comb begin
        ctrl_ofs = req_i.addr & ~CTRL_MASK;

        if ((req_i.addr & EMU_MASK) == EMU_BASE) begin
            region_d = REGION_EMU;
        end else if ((req_i.addr & CTRL_MASK) == CTRL_BASE) begin
            // Only one register lives in the control window
            if (ctrl_ofs == CTRL_DECOUPLE_OFS) begin
                region_d = REGION_CTRL;
            end else begin
                region_d = REGION_NONE;
            end
        end else begin
            // Old clock generator range falls through here too
            region_d = REGION_NONE;
        end
    end

    // ========================================================================
    // Stage register
    // ========================================================================
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (req_valid_i) begin
            dec_req_o.region <= region_d;
            dec_req_o.req    <= req_i;
        end
    end

endmodule

/* design/shell_bus_pkg.sv */
// Host bus definitions for the shell register path
// Widths, response codes, request and response structs

package shell_bus_pkg;

    // ========================================================================
    // Widths
    // ========================================================================
    localparam int ADDR_W     = 20;
    localparam int DATA_W     = 32;
    localparam int STRB_W     = DATA_W / 8;
    localparam int EMU_ADDR_W = 18;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [STRB_W-1:0]     strb_t;
    typedef logic [EMU_ADDR_W-1:0] emu_addr_t;

    // AXI response encoding, also used on the emulation port
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    // ========================================================================
    // Transfer structs
    // ========================================================================
    typedef struct packed {
        logic  write;
        addr_t addr;
        data_t wdata;
        strb_t strb;
    } bus_req_t;

    typedef struct packed {
        data_t rdata;
        resp_e resp;
    } bus_rsp_t;

    // Same request with the address reduced to the emulation window offset
    typedef struct packed {
        logic      write;
        emu_addr_t addr;
        data_t     wdata;
        strb_t     strb;
    } emu_req_t;

endpackage

/* design/shell_bus_top.sv */
// Top level of the shell register path
// Decode, execute and result stages with the emulation port

module shell_bus_top (
    input  logic                    aclk,
    input  logic                    aresetn,

    // Host request and response
    input  logic                    req_valid_i,
    input  shell_bus_pkg::bus_req_t req_i,
    output logic                    rsp_valid_o,
    output shell_bus_pkg::bus_rsp_t rsp_o,

    // Emulation target port
    output logic                    emu_req_valid_o,
    output shell_bus_pkg::emu_req_t emu_req_o,
    input  logic                    emu_rsp_valid_i,
    input  shell_bus_pkg::bus_rsp_t emu_rsp_i,

    output logic                    decouple_o
);

    import shell_bus_pkg::*;
    import shell_map_pkg::*;

    // ========================================================================
    // Stage links
    // ========================================================================
    logic     dec_valid;
    dec_req_t dec_req;
    logic     loc_valid;
    bus_rsp_t loc_rsp;
    logic     emu_issued;

    shell_addr_decode u_decode (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .dec_valid_o (dec_valid),
        .dec_req_o   (dec_req)
    );

    shell_ctrl_exec u_exec (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .dec_valid_i     (dec_valid),
        .dec_req_i       (dec_req),
        .loc_valid_o     (loc_valid),
        .loc_rsp_o       (loc_rsp),
        .emu_issued_o    (emu_issued),
        .emu_req_valid_o (emu_req_valid_o),
        .emu_req_o       (emu_req_o),
        .decouple_o      (decouple_o)
    );

    shell_resp_merge u_result (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .loc_valid_i     (loc_valid),
        .loc_rsp_i       (loc_rsp),
        .emu_issued_i    (emu_issued),
        .emu_rsp_valid_i (emu_rsp_valid_i),
        .emu_rsp_i       (emu_rsp_i),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_o           (rsp_o)
    );

endmodule

/* design/shell_ctrl_exec.sv */
// Execute stage of the shell register path
// Decouple register, local responses and emulation request forwarding

module shell_ctrl_exec (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic                    dec_valid_i,
    input  shell_map_pkg::dec_req_t dec_req_i,
    output logic                    loc_valid_o,
    output shell_bus_pkg::bus_rsp_t loc_rsp_o,
    output logic                    emu_issued_o,
    output logic                    emu_req_valid_o,
    output shell_bus_pkg::emu_req_t emu_req_o,
    output logic                    decouple_o
);

    import shell_bus_pkg::*;
    import shell_map_pkg::*;

    logic     decouple_q;
    logic     ctrl_wr;
    logic     emu_fwd;
    logic     loc_valid_d;
    data_t    ctrl_rdata;
    bus_rsp_t loc_rsp_d;

    // ========================================================================
    // Request handling
    // ========================================================================
    always_comb begin
        ctrl_rdata    = '0;
        ctrl_rdata[0] = decouple_q;

        ctrl_wr = dec_valid_i && (dec_req_i.region == REGION_CTRL) &&
                  dec_req_i.req.write && dec_req_i.req.strb[0];

        // Emulation accesses leave the shell only while coupled
        emu_fwd = dec_valid_i && (dec_req_i.region == REGION_EMU) && !decouple_q;

        loc_valid_d = dec_valid_i && !emu_fwd;

        loc_rsp_d.rdata = '0;
        loc_rsp_d.resp  = RESP_DECERR;
        case (dec_req_i.region)
            REGION_CTRL: begin
                if (!dec_req_i.req.write) begin
                    loc_rsp_d.rdata = ctrl_rdata;
                end
                loc_rsp_d.resp = RESP_OKAY;
            end
            REGION_EMU: begin
                if (decouple_q) begin
                    loc_rsp_d.resp = RESP_SLVERR;
                end else begin
                    // On a forwarded access rdata carries the read data mask
                    // that the result stage applies to the target's answer
                    loc_rsp_d.rdata = dec_req_i.req.write ? '0 : '1;
                    loc_rsp_d.resp  = RESP_OKAY;
                end
            end
            default: begin
                loc_rsp_d.resp = RESP_DECERR;
            end
        endcase
    end

    // ========================================================================
    // Control state
    // ========================================================================
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            loc_valid_o     <= 1'b0;
            emu_req_valid_o <= 1'b0;
            decouple_q      <= 1'b0;
        end else begin
            loc_valid_o     <= loc_valid_d;
            emu_req_valid_o <= emu_fwd;
            if (ctrl_wr) begin
                decouple_q <= dec_req_i.req.wdata[0];
            end
        end
    end

    // Payload registers
    always_ff @(posedge aclk) begin
        if (dec_valid_i) begin
            loc_rsp_o <= loc_rsp_d;
        end
        if (emu_fwd) begin
            emu_req_o.write <= dec_req_i.req.write;
            emu_req_o.addr  <= dec_req_i.req.addr[EMU_ADDR_W-1:0];
            emu_req_o.wdata <= dec_req_i.req.wdata;
            emu_req_o.strb  <= dec_req_i.req.strb;
        end
    end

    // The result stage starts its timeout with the outgoing request
    assign emu_issued_o = emu_req_valid_o;
    assign decouple_o   = decouple_q;

endmodule

/* design/shell_map_pkg.sv */
// Shell address map
// Window constants, region enum, emulation timeout and decoded request

package shell_map_pkg;

    // Emulation window covers 0x0_0000 to 0x3_FFFF
    localparam shell_bus_pkg::addr_t EMU_BASE  = 20'h0_0000;
    localparam shell_bus_pkg::addr_t EMU_MASK  = 20'hC_0000;

    // Shell control window at 0x5_xxxx
    localparam shell_bus_pkg::addr_t CTRL_BASE = 20'h5_0000;
    localparam shell_bus_pkg::addr_t CTRL_MASK = 20'hF_0000;

    // Bit 0 is the decouple control
    localparam shell_bus_pkg::addr_t CTRL_DECOUPLE_OFS = 20'h0_0000;

    typedef enum logic [1:0] {
        REGION_EMU,
        REGION_CTRL,
        REGION_NONE
    } region_e;

    // Cycles a forwarded access may wait for the target
    localparam int EMU_TIMEOUT = 16;
    localparam int TMO_CNT_W   = $clog2(EMU_TIMEOUT + 1);

    typedef struct packed {
        region_e                 region;
        shell_bus_pkg::bus_req_t req;
    } dec_req_t;

endpackage

/* design/shell_resp_merge.sv */
// Result stage of the shell register path
// Merges local and emulation responses, times out a silent target

module shell_resp_merge (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic                    loc_valid_i,
    input  shell_bus_pkg::bus_rsp_t loc_rsp_i,
    input  logic                    emu_issued_i,
    input  logic                    emu_rsp_valid_i,
    input  shell_bus_pkg::bus_rsp_t emu_rsp_i,
    output logic                    rsp_valid_o,
    output shell_bus_pkg::bus_rsp_t rsp_o
);

    import shell_bus_pkg::*;
    import shell_map_pkg::*;

    logic                 pending_q;
    logic [TMO_CNT_W-1:0] tmo_cnt_q;
    data_t                rd_mask_q;
    logic                 emu_done;
    logic                 emu_tmo;
    logic                 rsp_valid_d;
    bus_rsp_t             rsp_d;

    // ========================================================================
    // Response selection
    // ========================================================================
    always_comb begin
        // Answers with nothing outstanding are dropped here
        emu_done = pending_q && emu_rsp_valid_i;
        emu_tmo  = pending_q && !emu_rsp_valid_i && (tmo_cnt_q == EMU_TIMEOUT);

        rsp_valid_d = loc_valid_i || emu_done || emu_tmo;

        if (loc_valid_i) begin
            rsp_d = loc_rsp_i;
        end else if (emu_done) begin
            rsp_d.rdata = emu_rsp_i.rdata & rd_mask_q;
            rsp_d.resp  = emu_rsp_i.resp;
        end else begin
            rsp_d.rdata = '0;
            rsp_d.resp  = RESP_SLVERR;
        end
    end

    // ========================================================================
    // Outstanding access tracking
    // ========================================================================
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            pending_q   <= 1'b0;
            tmo_cnt_q   <= '0;
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= rsp_valid_d;
            if (emu_issued_i) begin
                pending_q <= 1'b1;
                tmo_cnt_q <= TMO_CNT_W'(1);
            end else if (emu_done || emu_tmo) begin
                pending_q <= 1'b0;
                tmo_cnt_q <= '0;
            end else if (pending_q) begin
                tmo_cnt_q <= tmo_cnt_q + 1'b1;
            end
        end
    end

    // Payload registers
    always_ff @(posedge aclk) begin
        // Writes get a zero mask so rdata reads back as 0
        if (emu_issued_i) begin
            rd_mask_q <= loc_rsp_i.rdata;
        end
        if (rsp_valid_d) begin
            rsp_o <= rsp_d;
        end
    end

endmodule

/* dv/shell_bus_tests.svh */
// Reference model, compare tasks and the six directed random tests
// Included inside the testbench top module

    logic model_decouple = 1'b0;

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    // Address in 0x4_xxxx or 0x6_xxxx to 0xF_xxxx
    function automatic addr_t unmapped_addr();
        logic [3:0] hi;
        hi = (rand32() % 11 == 0) ? 4'h4 : 4'h6 + 4'(rand32() % 10);
        return {hi, 16'(rand32())};
    endfunction

    // ========================================================================
    // Reference model and compare tasks
    // ========================================================================
    task automatic predict(input bus_req_t r, output bus_rsp_t exp, output bit fwd);
        exp.rdata = '0;
        exp.resp  = RESP_DECERR;
        fwd       = 1'b0;
        if ((r.addr & EMU_MASK) == EMU_BASE) begin
            fwd      = !model_decouple;
            exp.resp = model_decouple ? RESP_SLVERR : RESP_OKAY;
        end else if (r.addr == (CTRL_BASE | CTRL_DECOUPLE_OFS)) begin
            exp.resp = RESP_OKAY;
            if (!r.write) begin
                exp.rdata = {31'b0, model_decouple};
            end else if (r.strb[0]) begin
                model_decouple = r.wdata[0];
            end
        end
    endtask

    task automatic report_failure(input string what);
        err_cnt++;
        $display("%s", what);
    endtask

    task automatic check_rsp(input string name, input bus_rsp_t exp, input bus_rsp_t act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("error: %s expected rdata=%h resp=%h actual rdata=%h resp=%h",
                     name, exp.rdata, exp.resp, act.rdata, act.resp);
        end
    endtask

    task automatic check_emu_req(input string name, input emu_req_t exp, input emu_req_t act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("error: %s expected emu request %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_decouple(input string name, input logic exp, input logic act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("error: %s expected decouple=%b actual decouple=%b", name, exp, act);
        end
    endtask

    task automatic check_delay(input string name, input int exp, input int act);
        check_cnt++;
        if (act != exp) begin
            err_cnt++;
            $display("error: %s expected %0d cycles actual %0d cycles", name, exp, act);
        end
    endtask

    // ========================================================================
    // Request driving
    // ========================================================================
    task automatic issue(input bus_req_t r);
        req_valid_i = 1'b1;
        req_i       = r;
        @(posedge aclk);
        #1;
        req_valid_i = 1'b0;
    endtask

    task automatic await_rsp(input string name, input int count);
        int waited;
        waited = 0;
        while (rsp_q.size() < count && waited < EMU_TIMEOUT + 10) begin
            @(posedge aclk);
            #1;
            waited++;
        end
        if (rsp_q.size() < count) begin
            report_failure($sformatf("%s: response missing after %0d cycles", name, waited));
        end
    endtask

    // One request checked end to end, local or forwarded
    task automatic access(input string name, input bus_req_t r);
        bus_rsp_t    exp;
        bus_rsp_t    act;
        bus_rsp_t    tgt;
        emu_req_t    exp_emu;
        bit          fwd;
        int unsigned t_req;
        int unsigned t_rsp;
        int unsigned t_emu;
        int unsigned t_tgt;
        predict(r, exp, fwd);
        t_req = cyc_cnt;
        issue(r);
        await_rsp(name, 1);
        if (rsp_q.size() == 0) begin
            return;
        end
        act   = rsp_q.pop_front();
        t_rsp = rsp_cyc_q.pop_front();
        if (!fwd) begin
            check_delay(name, 3, t_rsp - t_req);
            if (emu_q.size() != 0) begin
                report_failure($sformatf("%s: request leaked to the emulation port", name));
                emu_q.delete();
                emu_cyc_q.delete();
            end
        end else if (emu_q.size() == 0) begin
            report_failure($sformatf("%s: no request on the emulation port", name));
            return;
        end else begin
            exp_emu.write = r.write;
            exp_emu.addr  = r.addr[EMU_ADDR_W-1:0];
            exp_emu.wdata = r.wdata;
            exp_emu.strb  = r.strb;
            t_emu = emu_cyc_q.pop_front();
            check_emu_req(name, exp_emu, emu_q.pop_front());
            check_delay(name, 2, t_emu - t_req);
            if (target_silent) begin
                exp.rdata = '0;
                exp.resp  = RESP_SLVERR;
                check_delay(name, EMU_TIMEOUT + 1, t_rsp - t_emu);
            end else if (tgt_q.size() == 0) begin
                report_failure($sformatf("%s: target model never answered", name));
                return;
            end else begin
                tgt       = tgt_q.pop_front();
                t_tgt     = tgt_cyc_q.pop_front();
                exp.rdata = r.write ? '0 : tgt.rdata;
                exp.resp  = tgt.resp;
                check_delay(name, 1, t_rsp - t_tgt);
            end
        end
        check_rsp(name, exp, act);
        check_decouple(name, model_decouple, decouple_o);
    endtask

    task automatic write_decouple(input string name, input logic value);
        bus_req_t r;
        r       = '0;
        r.write = 1'b1;
        r.addr  = CTRL_BASE | CTRL_DECOUPLE_OFS;
        r.wdata = {31'b0, value};
        r.strb  = 4'h1;
        access(name, r);
    endtask

    function automatic bus_req_t emu_req_rand();
        bus_req_t r;
        r.write = 1'(rand32());
        r.addr  = (addr_t'(rand32()) & ~EMU_MASK) | EMU_BASE;
        r.wdata = rand32();
        r.strb  = strb_t'(rand32());
        return r;
    endfunction

    task automatic report_test(input string name, input int e0, input int c0);
        test_cnt++;
        $display("%-18s %0d checks, %0d errors", name, check_cnt - c0, err_cnt - e0);
    endtask

    // ========================================================================
    // Tests
    // ========================================================================
    task automatic ctrl_register_rw();
        int       e0;
        int       c0;
        bus_req_t r;
        e0 = err_cnt;
        c0 = check_cnt;
        check_cnt++;
        if (rsp_valid_o || emu_req_valid_o || decouple_o) begin
            report_failure("ctrl_register_rw: an output is high after reset");
        end
        r      = '0;
        r.addr = CTRL_BASE | CTRL_DECOUPLE_OFS;
        access("ctrl_register_rw", r);
        for (int i = 0; i < N_REQ / 2; i++) begin
            r.write = 1'b1;
            r.wdata = rand32();
            r.strb  = strb_t'(rand32());
            access("ctrl_register_rw", r);
            r.write = 1'b0;
            access("ctrl_register_rw", r);
        end
        report_test("ctrl_register_rw", e0, c0);
    endtask

    task automatic emu_forwarding();
        int e0;
        int c0;
        e0 = err_cnt;
        c0 = check_cnt;
        write_decouple("emu_forwarding", 1'b0);
        for (int i = 0; i < N_REQ; i++) begin
            access("emu_forwarding", emu_req_rand());
        end
        report_test("emu_forwarding", e0, c0);
    endtask

    task automatic decouple_blocking();
        int e0;
        int c0;
        e0 = err_cnt;
        c0 = check_cnt;
        write_decouple("decouple_blocking", 1'b1);
        for (int i = 0; i < N_REQ / 2; i++) begin
            access("decouple_blocking", emu_req_rand());
        end
        // Coupled again, forwarding resumes
        write_decouple("decouple_blocking", 1'b0);
        for (int i = 0; i < 4; i++) begin
            access("decouple_blocking", emu_req_rand());
        end
        report_test("decouple_blocking", e0, c0);
    endtask

    task automatic unmapped_decerr();
        int          e0;
        int          c0;
        logic [15:0] ofs;
        bus_req_t    r;
        e0 = err_cnt;
        c0 = check_cnt;
        for (int i = 0; i < N_REQ; i++) begin
            r       = emu_req_rand();
            r.addr  = unmapped_addr();
            ofs     = 16'(rand32());
            if (i % 3 == 2) begin
                r.addr = CTRL_BASE | {4'h0, (ofs == 16'h0) ? 16'h0004 : ofs};
            end
            access("unmapped_decerr", r);
        end
        report_test("unmapped_decerr", e0, c0);
    endtask

    task automatic emu_timeout();
        int e0;
        int c0;
        e0 = err_cnt;
        c0 = check_cnt;
        write_decouple("emu_timeout", 1'b0);
        target_silent = 1'b1;
        for (int i = 0; i < 4; i++) begin
            access("emu_timeout", emu_req_rand());
        end
        target_silent = 1'b0;
        report_test("emu_timeout", e0, c0);
    endtask

    task automatic back_to_back();
        int          e0;
        int          c0;
        bit          fwd;
        bus_req_t    r;
        bus_rsp_t    exp;
        bus_rsp_t    exp_q[$];
        int unsigned t_q[$];
        int unsigned t_req;
        e0 = err_cnt;
        c0 = check_cnt;
        for (int i = 0; i < N_REQ; i++) begin
            r      = emu_req_rand();
            r.addr = rand32() % 2 == 0 ? (CTRL_BASE | CTRL_DECOUPLE_OFS) : unmapped_addr();
            predict(r, exp, fwd);
            exp_q.push_back(exp);
            t_q.push_back(cyc_cnt);
            issue(r);
        end
        await_rsp("back_to_back", N_REQ);
        while (exp_q.size() != 0 && rsp_q.size() != 0) begin
            t_req = t_q.pop_front();
            check_rsp("back_to_back", exp_q.pop_front(), rsp_q.pop_front());
            check_delay("back_to_back", 3, rsp_cyc_q.pop_front() - t_req);
        end
        check_decouple("back_to_back", model_decouple, decouple_o);
        report_test("back_to_back", e0, c0);
    endtask

/* dv/tb_shell_bus.sv */
// Testbench top for the shell register path
// Clock, reset, DUT, emulation target model, output monitor and watchdog

module tb_shell_bus;

    timeunit 1ns;
    timeprecision 1ps;

    import shell_bus_pkg::*;
    import shell_map_pkg::*;

    localparam int N_TESTS   = 6;
    localparam int N_REQ     = 24;
    localparam int WD_CYCLES = N_TESTS * N_REQ * (EMU_TIMEOUT + 10);

    logic     aclk = 1'b0;
    logic     aresetn;
    logic     req_valid_i;
    bus_req_t req_i;
    logic     rsp_valid_o;
    bus_rsp_t rsp_o;
    logic     emu_req_valid_o;
    emu_req_t emu_req_o;
    logic     emu_rsp_valid_i;
    bus_rsp_t emu_rsp_i;
    logic     decouple_o;

    integer      seed          = 32'h3f83d9ee;
    integer      tgt_seed      = 32'h3f83d9ee ^ 32'h0000_5a5a;
    int unsigned cyc_cnt       = 0;
    bit          target_silent = 1'b0;
    int          err_cnt       = 0;
    int          check_cnt     = 0;
    int          test_cnt      = 0;

    // Monitor queues, filled at the falling edge
    bus_rsp_t    rsp_q[$];
    int unsigned rsp_cyc_q[$];
    emu_req_t    emu_q[$];
    int unsigned emu_cyc_q[$];
    bus_rsp_t    tgt_q[$];
    int unsigned tgt_cyc_q[$];

    shell_bus_top u_shell_bus_top (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .req_valid_i     (req_valid_i),
        .req_i           (req_i),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_o           (rsp_o),
        .emu_req_valid_o (emu_req_valid_o),
        .emu_req_o       (emu_req_o),
        .emu_rsp_valid_i (emu_rsp_valid_i),
        .emu_rsp_i       (emu_rsp_i),
        .decouple_o      (decouple_o)
    );

    always #5 aclk = ~aclk;

    always @(posedge aclk) begin
        cyc_cnt <= cyc_cnt + 1;
    end

    always @(negedge aclk) begin
        if (rsp_valid_o) begin
            rsp_q.push_back(rsp_o);
            rsp_cyc_q.push_back(cyc_cnt);
        end
        if (emu_req_valid_o) begin
            emu_q.push_back(emu_req_o);
            emu_cyc_q.push_back(cyc_cnt);
        end
    end

    // ========================================================================
    // Emulation target, answers after 1 to 8 cycles unless silent
    // ========================================================================
    initial begin : target_model
        int       delay;
        int       sel;
        bus_rsp_t rsp;
        emu_rsp_valid_i = 1'b0;
        emu_rsp_i       = '0;
        forever begin
            @(posedge aclk);
            #1;
            if (emu_req_valid_o && !target_silent) begin
                delay     = 1 + ($random(tgt_seed) & 7);
                sel       = $random(tgt_seed) & 3;
                rsp.rdata = $random(tgt_seed);
                rsp.resp  = (sel == 1) ? RESP_SLVERR : (sel == 2) ? RESP_DECERR : RESP_OKAY;
                repeat (delay) begin
                    @(posedge aclk);
                    #1;
                end
                emu_rsp_valid_i = 1'b1;
                emu_rsp_i       = rsp;
                tgt_q.push_back(rsp);
                tgt_cyc_q.push_back(cyc_cnt);
                @(posedge aclk);
                #1;
                emu_rsp_valid_i = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (WD_CYCLES) @(posedge aclk);
        $display("Watchdog expired after %0d cycles, the tests did not complete", WD_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    `include "shell_bus_tests.svh"

    initial begin
        aresetn     = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        repeat (3) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        ctrl_register_rw();
        emu_forwarding();
        decouple_blocking();
        unmapped_decerr();
        emu_timeout();
        back_to_back();
        $display("Summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+dv
design/shell_bus_pkg.sv
design/shell_map_pkg.sv
design/shell_addr_decode.sv
design/shell_ctrl_exec.sv
design/shell_resp_merge.sv
design/shell_bus_top.sv
dv/tb_shell_bus.sv
